//--- hw/lsu_pkg.sv
/*
  Access description shared by the load/store unit and its testbench.
  Holds the access type encoding and small helpers that turn a type and a
  lane offset into byte counts and the two-beat split decision.
*/
package lsu_pkg;

  // access type with the core interface encoding
  typedef enum logic [1:0] {
    ACC_WORD   = 2'b00,
    ACC_HALF   = 2'b01,
    ACC_BYTE   = 2'b10,
    ACC_DOUBLE = 2'b11
  } access_type_e;

  // number of bytes touched by one access of the given type
  function automatic logic [3:0] access_bytes(access_type_e acc_type);
    unique case (acc_type)
      ACC_BYTE:   return 4'd1;
      ACC_HALF:   return 4'd2;
      ACC_WORD:   return 4'd4;
      default:    return 4'd8; // double
    endcase
  endfunction

  // true when the access runs past lane 7 and needs a second beat
  // doubles are always aligned and never split
  function automatic logic is_split(access_type_e acc_type, logic [2:0] offset);
    logic [3:0] end_lane; // one past the last lane used
    end_lane = {1'b0, offset} + access_bytes(acc_type);
    return (acc_type != ACC_DOUBLE) && (end_lane > 4'd8);
  endfunction

endpackage

//--- hw/lsu_bus_pkg.sv
/*
  Geometry of the 64-bit data bus behind the load/store unit.
  Lane logic in the RTL is written for eight byte lanes.
*/
package lsu_bus_pkg;

  localparam int unsigned BusBytes     = 8;           // byte lanes per beat
  localparam int unsigned BusWidth     = 8 * BusBytes; // data bits per beat
  localparam int unsigned LaneIdxWidth = 3;           // bits to pick a lane

  typedef logic [BusWidth-1:0]     bus_data_t;  // one data beat
  typedef logic [BusBytes-1:0]     bus_be_t;    // one enable per lane
  typedef logic [LaneIdxWidth-1:0] lane_idx_t;  // lane offset in a beat

endpackage

//--- hw/lsu_store_lanes.sv
/*
  Store lane steering. Rotates the core's write data so byte k lands in
  lane (k + offset) mod 8 and builds the byte enables of the current beat.
  Purely combinational, fed from the latched request in the control FSM.
*/
`timescale 1ns/100ps

module lsu_store_lanes (
  input  lsu_pkg::access_type_e   type_i,        // latched access type
  input  lsu_bus_pkg::lane_idx_t  offset_i,      // start lane of the access
  input  logic                    second_beat_i, // high while the upper beat is out
  input  lsu_bus_pkg::bus_data_t  wdata_i,       // write data, byte 0 is lsb
  output lsu_bus_pkg::bus_be_t    data_be_o,
  output lsu_bus_pkg::bus_data_t  data_wdata_o
);

  import lsu_pkg::*;
  import lsu_bus_pkg::*;

  localparam int unsigned SpanWidth = 2 * BusBytes; // lanes of two beats

  logic [SpanWidth-1:0] acc_mask;  // one bit per access byte, from lane 0
  logic [SpanWidth-1:0] span_mask; // same mask moved to the start lane
  bus_data_t            wdata_rot;

  ////////////////////////////////////////////////////////////////////////////
  // byte enables

  assign acc_mask  = (SpanWidth'(1) << access_bytes(type_i)) - SpanWidth'(1);
  assign span_mask = acc_mask << offset_i;

  // low half of the span goes out on the first beat, the overflow on the second
  always_comb begin
    if (type_i == ACC_DOUBLE) begin
      data_be_o = '1; // doubles are aligned, all lanes
    end else if (second_beat_i) begin
      data_be_o = span_mask[SpanWidth-1 -: BusBytes];
    end else begin
      data_be_o = span_mask[BusBytes-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write data rotation

  // lane l takes source byte (l - offset) mod 8, the 3-bit cast does the wrap
  always_comb begin
    for (int unsigned lane = 0; lane < BusBytes; lane++) begin
      wdata_rot[8*lane +: 8] = wdata_i[8*lane_idx_t'(lane - offset_i) +: 8];
    end
  end

  // the same rotated word serves both beats, the enables pick the lanes
  assign data_wdata_o = (type_i == ACC_DOUBLE) ? wdata_i : wdata_rot;

endmodule

//--- hw/lsu_load_align.sv
/*
  Load data path. Keeps the first beat of a split load, gathers the access
  bytes from the lane offset onwards and zero or sign extends the result
  to 64 bits. The output is valid in the cycle the last beat returns.
*/
`timescale 1ns/100ps

module lsu_load_align (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    capture_first_i, // first beat of a split load is on the bus
  input  lsu_pkg::access_type_e   type_i,
  input  lsu_bus_pkg::lane_idx_t  offset_i,
  input  logic                    sign_ext_i,
  input  lsu_bus_pkg::bus_data_t  data_rdata_i,
  output lsu_bus_pkg::bus_data_t  rdata_o
);

  import lsu_pkg::*;
  import lsu_bus_pkg::*;

  logic                  split;     // access spans two beats
  bus_data_t             first_q;   // lower beat of a split load
  logic [2*BusWidth-1:0] window;    // two beats, lower one first
  bus_data_t             gathered;  // access bytes moved down to lane 0
  logic                  sign_bit;

  ////////////////////////////////////////////////////////////////////////////
  // first beat capture

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= '0;
    end else if (capture_first_i) begin
      first_q <= data_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte gathering

  assign split = is_split(type_i, offset_i);

  // a split load continues from the held beat into the low lanes of the new one;
  // otherwise every access byte already sits in the current beat
  assign window   = {data_rdata_i, split ? first_q : data_rdata_i};
  assign gathered = bus_data_t'(window >> {offset_i, 3'b000});

  // msb of the loaded value, by type
  always_comb begin
    unique case (type_i)
      ACC_BYTE: sign_bit = gathered[7];
      ACC_HALF: sign_bit = gathered[15];
      default:  sign_bit = gathered[31]; // word; unused for doubles
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // extension

  always_comb begin
    unique case (type_i)
      ACC_BYTE: begin
        rdata_o = {{(BusWidth-8){sign_ext_i & sign_bit}}, gathered[7:0]};
      end
      ACC_HALF: begin
        rdata_o = {{(BusWidth-16){sign_ext_i & sign_bit}}, gathered[15:0]};
      end
      ACC_WORD: begin
        rdata_o = {{(BusWidth-32){sign_ext_i & sign_bit}}, gathered[31:0]};
      end
      default: begin
        rdata_o = data_rdata_i; // double comes back raw, aligned
      end
    endcase
  end

endmodule

//--- hw/lsu_ctrl_fsm.sv
/*
  Load/store control. Latches the core strobe, decides whether the access
  needs two bus beats and runs the request/grant/valid handshake. Drives
  the lane and extension controls for the two data path blocks and reports
  completion and bus errors back to the core.
*/
`timescale 1ns/100ps

module lsu_ctrl_fsm #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core strobe
  input  logic                    req_i,
  input  logic [AddrWidth-1:0]    addr_i,
  input  lsu_pkg::access_type_e   type_i,
  input  logic                    we_i,
  input  lsu_bus_pkg::bus_data_t  wdata_i,
  input  logic                    sign_ext_i,
  // bus handshake
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  output logic                    data_req_o,
  output logic [AddrWidth-1:0]    data_addr_o,
  output logic                    data_we_o,
  // controls for the lane and align blocks
  output lsu_pkg::access_type_e   type_o,
  output lsu_bus_pkg::lane_idx_t  offset_o,
  output lsu_bus_pkg::bus_data_t  wdata_o,     // held write data
  output logic                    sign_ext_o,
  output logic                    second_beat_o,
  output logic                    capture_first_o,
  // completion
  output logic                    valid_o,
  output logic                    load_err_o,
  output logic                    store_err_o,
  output logic                    busy_o
);

  import lsu_pkg::*;
  import lsu_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE, WAIT_GNT, WAIT_RVALID, WAIT_GNT_MIS, WAIT_RVALID_MIS
  } ls_state_e;

  ls_state_e            state_q, state_d;
  logic                 accept;      // strobe taken this cycle
  logic                 second_q;    // upper beat of a split is in flight
  logic                 first_done;  // first beat of a split came back clean
  logic [AddrWidth-1:0] addr_q;
  access_type_e         type_q;
  logic                 we_q;
  logic                 sign_q;
  bus_data_t            wdata_q;
  logic [AddrWidth-1:0] beat_base;   // aligned address of the first beat

  assign accept     = req_i && (state_q == IDLE);
  assign first_done = (state_q == WAIT_RVALID_MIS) && data_rvalid_i && !data_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // request latch

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      type_q  <= type_i;
      we_q    <= we_i;
      sign_q  <= sign_ext_i;
      wdata_q <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM

  always_comb begin
    state_d         = state_q;
    data_req_o      = 1'b0;
    valid_o         = 1'b0;
    capture_first_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = is_split(type_i, addr_i[LaneIdxWidth-1:0]) ? WAIT_GNT_MIS : WAIT_GNT;
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) state_d = WAIT_RVALID_MIS;
      end
      WAIT_RVALID_MIS: begin
        if (data_rvalid_i) begin
          if (data_err_i) begin
            valid_o = 1'b1; // abort, no second beat
            state_d = IDLE;
          end else begin
            data_req_o      = 1'b1; // second beat goes out right away
            capture_first_o = !we_q;
            state_d         = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) state_d = WAIT_RVALID;
      end
      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      second_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (first_done) begin
        second_q <= 1'b1;
      end else if (valid_o) begin
        second_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs

  // second beat is already selected while its request rides on the first rvalid
  assign second_beat_o = second_q || (state_q == WAIT_RVALID_MIS);

  assign beat_base   = {addr_q[AddrWidth-1:LaneIdxWidth], LaneIdxWidth'(0)};
  assign data_addr_o = second_beat_o ? beat_base + AddrWidth'(BusBytes) : beat_base;
  assign data_we_o   = we_q;

  assign type_o     = type_q;
  assign offset_o   = addr_q[LaneIdxWidth-1:0];
  assign wdata_o    = wdata_q;
  assign sign_ext_o = sign_q;

  // error belongs to whichever beat finished the access
  assign load_err_o  = valid_o && data_err_i && !we_q;
  assign store_err_o = valid_o && data_err_i && we_q;
  assign busy_o      = (state_q != IDLE);

endmodule

//--- hw/lsu_top.sv
/*
  Load/store unit top level. Takes a one-cycle access strobe from the core
  and runs it on the 64-bit request/grant/valid data bus, one or two beats
  per access. Completion comes back as a one-cycle valid_o.
*/
`timescale 1ns/100ps

module lsu_top #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core side
  input  logic                    req_i,       // single-cycle strobe, only while !busy_o
  input  logic [AddrWidth-1:0]    addr_i,
  input  lsu_pkg::access_type_e   type_i,
  input  logic                    we_i,
  input  lsu_bus_pkg::bus_data_t  wdata_i,
  input  logic                    sign_ext_i,
  output logic                    valid_o,
  output lsu_bus_pkg::bus_data_t  rdata_o,
  output logic                    load_err_o,
  output logic                    store_err_o,
  output logic                    busy_o,
  // data bus
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  input  lsu_bus_pkg::bus_data_t  data_rdata_i,
  output logic [AddrWidth-1:0]    data_addr_o, // always 8-byte aligned
  output logic                    data_we_o,
  output lsu_bus_pkg::bus_be_t    data_be_o,
  output lsu_bus_pkg::bus_data_t  data_wdata_o
);

  import lsu_pkg::*;
  import lsu_bus_pkg::*;

  access_type_e acc_type;      // latched request fields
  lane_idx_t    acc_offset;
  bus_data_t    acc_wdata;
  logic         acc_sign_ext;
  logic         second_beat;
  logic         capture_first;

  lsu_ctrl_fsm #(
    .AddrWidth (AddrWidth)
  ) u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .type_i          (type_i),
    .we_i            (we_i),
    .wdata_i         (wdata_i),
    .sign_ext_i      (sign_ext_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .type_o          (acc_type),
    .offset_o        (acc_offset),
    .wdata_o         (acc_wdata),
    .sign_ext_o      (acc_sign_ext),
    .second_beat_o   (second_beat),
    .capture_first_o (capture_first),
    .valid_o         (valid_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o)
  );

  lsu_store_lanes u_store (
    .type_i        (acc_type),
    .offset_i      (acc_offset),
    .second_beat_i (second_beat),
    .wdata_i       (acc_wdata),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align u_load (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .capture_first_i (capture_first),
    .type_i          (acc_type),
    .offset_i        (acc_offset),
    .sign_ext_i      (acc_sign_ext),
    .data_rdata_i    (data_rdata_i),
    .rdata_o         (rdata_o)
  );

endmodule

//--- test/lsu_mem_model.sv
/*
  Byte-addressed memory behind the 64-bit data bus, for simulation only.
  Grants after 0 to 2 cycles and answers 1 to 3 cycles after the grant,
  one beat at a time. Beats flagged in fault_beat answer with an error
  and leave the memory untouched.
*/
`timescale 1ns/100ps

module lsu_mem_model #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned MemBytes  = 1024
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    data_req_i,
  input  logic [AddrWidth-1:0]    data_addr_i,
  input  logic                    data_we_i,
  input  lsu_bus_pkg::bus_be_t    data_be_i,
  input  lsu_bus_pkg::bus_data_t  data_wdata_i,
  output logic                    data_gnt_o,
  output logic                    data_rvalid_o,
  output logic                    data_err_o,
  output lsu_bus_pkg::bus_data_t  data_rdata_o
);

  import lsu_bus_pkg::*;

  localparam int unsigned NumBeats = MemBytes / BusBytes;

  logic [7:0]  mem [MemBytes];        // byte storage
  logic        fault_beat [NumBeats]; // set from the testbench by hierarchy
  logic        pend_q;                // granted beat waiting for its answer
  logic [1:0]  gnt_cnt_q;             // cycles left before the next grant
  logic [1:0]  rsp_cnt_q;             // cycles left before rvalid
  logic        err_q;
  bus_data_t   rdata_q;
  int unsigned beat;                  // beat index of the current address

  // fill pattern mixes low and high address bits
  initial begin
    for (int i = 0; i < MemBytes; i++) begin
      mem[i] = 8'(i * 37) ^ 8'(i >> 5);
    end
    for (int i = 0; i < NumBeats; i++) begin
      fault_beat[i] = 1'b0;
    end
  end

  assign beat          = (data_addr_i / BusBytes) % NumBeats;
  assign data_rvalid_o = pend_q && (rsp_cnt_q == 2'd0);
  assign data_err_o    = data_rvalid_o && err_q;
  assign data_rdata_o  = rdata_q;
  // a new beat may be granted in the cycle the old one answers
  assign data_gnt_o    = data_req_i && (gnt_cnt_q == 2'd0) && (!pend_q || data_rvalid_o);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      gnt_cnt_q <= 2'd0;
      rsp_cnt_q <= 2'd0;
      err_q     <= 1'b0;
      rdata_q   <= '0;
    end else begin
      if (data_rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        rsp_cnt_q <= rsp_cnt_q - 2'd1;
      end
      if (data_req_i && (gnt_cnt_q != 2'd0)) begin
        gnt_cnt_q <= gnt_cnt_q - 2'd1; // request waits out the grant delay
      end
      if (data_gnt_o) begin
        pend_q    <= 1'b1; // overrides the clear above on back-to-back beats
        gnt_cnt_q <= 2'($urandom_range(0, 2));
        rsp_cnt_q <= 2'($urandom_range(0, 2));
        err_q     <= fault_beat[beat];
        for (int l = 0; l < BusBytes; l++) begin
          rdata_q[8*l +: 8] <= mem[beat*BusBytes + l];
          if (data_we_i && data_be_i[l] && !fault_beat[beat]) begin
            mem[beat*BusBytes + l] <= data_wdata_i[8*l +: 8];
          end
        end
      end
    end
  end

endmodule

//--- test/tb_lsu.sv
/*
  Directed testbench for the load/store unit. Loads, stores, split
  accesses, bus errors and a seeded random mix run against a byte array
  that mirrors the memory model behind the data bus.
*/
`timescale 1ns/100ps

module tb_lsu;

  import lsu_pkg::*;
  import lsu_bus_pkg::*;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned MemBytes    = 1024;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned NumAccesses = 64 + 32 + 4 + 200; // loads, stores, errors, random
  localparam int unsigned MaxCycles   = 20 * NumAccesses + ResetCycles;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic [AddrWidth-1:0] addr;
  access_type_e         acc_type;
  logic                 we;
  bus_data_t            wdata;
  logic                 sign_ext;
  logic                 valid;
  bus_data_t            rdata;
  logic                 load_err;
  logic                 store_err;
  logic                 busy;
  logic                 data_req;
  logic                 data_gnt;
  logic                 data_rvalid;
  logic                 data_err;
  bus_data_t            data_rdata;
  logic [AddrWidth-1:0] data_addr;
  logic                 data_we;
  bus_be_t              data_be;
  bus_data_t            data_wdata;

  logic [7:0]           ref_mem [MemBytes];  // expected memory contents
  logic [AddrWidth-1:0] beat_addr_q [$];     // granted beat addresses of one access
  logic                 beat_we_q [$];       // write enable of each granted beat
  int unsigned          cycles;

  lsu_top #(
    .AddrWidth (AddrWidth)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .addr_i        (addr),
    .type_i        (acc_type),
    .we_i          (we),
    .wdata_i       (wdata),
    .sign_ext_i    (sign_ext),
    .valid_o       (valid),
    .rdata_o       (rdata),
    .load_err_o    (load_err),
    .store_err_o   (store_err),
    .busy_o        (busy),
    .data_req_o    (data_req),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_err_i    (data_err),
    .data_rdata_i  (data_rdata),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_be_o     (data_be),
    .data_wdata_o  (data_wdata)
  );

  lsu_mem_model #(
    .AddrWidth (AddrWidth),
    .MemBytes  (MemBytes)
  ) u_mem (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .data_req_i    (data_req),
    .data_addr_i   (data_addr),
    .data_we_i     (data_we),
    .data_be_i     (data_be),
    .data_wdata_i  (data_wdata),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_err_o    (data_err),
    .data_rdata_o  (data_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period

  ////////////////////////////////////////////////////////////////////////////
  // checking helpers

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, sig, exp, got);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // hung run guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // bus monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && data_req && data_gnt) begin
      assert (data_addr[2:0] == 3'b000)
        else report_mismatch("data_addr_o[2:0]", 64'd0, 64'(data_addr[2:0]));
      beat_addr_q.push_back(data_addr);
      beat_we_q.push_back(data_we);
    end
  end

  function automatic int size_of(access_type_e t);
    case (t)
      ACC_BYTE: return 1;
      ACC_HALF: return 2;
      ACC_WORD: return 4;
      default:  return 8;
    endcase
  endfunction

  // two beats when the access runs past lane 7, doubles never split
  function automatic logic needs_two_beats(access_type_e t, logic [AddrWidth-1:0] a);
    return (t != ACC_DOUBLE) && (int'(a[2:0]) + size_of(t) > 8);
  endfunction

  function automatic int unsigned start_of(access_type_e t, logic [AddrWidth-1:0] a);
    return (t == ACC_DOUBLE) ? int'(a & ~32'd7) : int'(a); // double ignores low bits
  endfunction

  function automatic logic [63:0] expected_load(access_type_e t, logic [AddrWidth-1:0] a,
                                                logic sx);
    logic [63:0] v;
    int          n;
    n = size_of(t);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = ref_mem[start_of(t, a) + k];
    end
    if (sx && (n < 8) && v[8*n-1]) begin
      v = v | ~((64'd1 << (8*n)) - 64'd1);
    end
    return v;
  endfunction

  task automatic compare_memory();
    for (int i = 0; i < MemBytes; i++) begin
      assert (u_mem.mem[i] == ref_mem[i])
        else report_mismatch($sformatf("mem[%0d]", i), 64'(ref_mem[i]), 64'(u_mem.mem[i]));
    end
  endtask

  task automatic check_beats(input logic [AddrWidth-1:0] a, input int n, input logic wr);
    assert (beat_addr_q.size() == n)
      else report_mismatch("bus beat count", 64'(n), 64'(beat_addr_q.size()));
    for (int i = 0; i < n; i++) begin
      assert (beat_addr_q[i] == (a & ~32'd7) + 32'(8*i))
        else report_mismatch("data_addr_o", 64'((a & ~32'd7) + 32'(8*i)),
                             64'(beat_addr_q[i]));
      assert (beat_we_q[i] == wr)
        else report_mismatch("data_we_o", 64'(wr), 64'(beat_we_q[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one access on the core side

  task automatic run_access(input logic wr, input access_type_e t,
                            input logic [AddrWidth-1:0] a, input logic [63:0] wd,
                            input logic sx, output logic [63:0] rd,
                            output logic lerr, output logic serr);
    logic done;
    done = 1'b0;
    @(posedge clk);
    #10;
    req      = 1'b1;
    we       = wr;
    acc_type = t;
    addr     = a;
    wdata    = wd;
    sign_ext = sx;
    @(negedge clk);
    assert (!busy) else report_mismatch("busy_o", 64'd0, 64'(busy)); // idle before strobe
    assert (!valid) else report_mismatch("valid_o", 64'd0, 64'(valid));
    beat_addr_q.delete();
    beat_we_q.delete();
    @(posedge clk);
    #10;
    req = 1'b0;
    while (!done) begin
      @(negedge clk);
      assert (busy) else report_mismatch("busy_o", 64'd1, 64'(busy));
      if (valid) begin
        rd   = rdata;
        lerr = load_err;
        serr = store_err;
        done = 1'b1;
      end else begin
        assert (!load_err && !store_err)
          else report_mismatch("load_err_o/store_err_o", 64'd0, {load_err, store_err});
      end
    end
  endtask

  task automatic load_and_check(input access_type_e t, input logic [AddrWidth-1:0] a,
                                input logic sx);
    logic [63:0] rd;
    logic        lerr;
    logic        serr;
    run_access(1'b0, t, a, 64'(0), sx, rd, lerr, serr);
    assert (rd == expected_load(t, a, sx))
      else report_mismatch("rdata_o", expected_load(t, a, sx), rd);
    assert (!lerr && !serr) else report_mismatch("load_err_o/store_err_o", 64'd0, {lerr, serr});
    check_beats(a, needs_two_beats(t, a) ? 2 : 1, 1'b0);
  endtask

  task automatic store_and_check(input access_type_e t, input logic [AddrWidth-1:0] a,
                                 input logic [63:0] wd);
    logic [63:0] rd;
    logic        lerr;
    logic        serr;
    run_access(1'b1, t, a, wd, 1'b0, rd, lerr, serr);
    for (int k = 0; k < size_of(t); k++) begin
      ref_mem[start_of(t, a) + k] = wd[8*k +: 8];
    end
    assert (!lerr && !serr) else report_mismatch("load_err_o/store_err_o", 64'd0, {lerr, serr});
    check_beats(a, needs_two_beats(t, a) ? 2 : 1, 1'b1);
    compare_memory(); // bytes outside the access must be untouched
  endtask

  // fault on the first beat, single or split, ends the access at once
  task automatic error_case(input logic wr, input access_type_e t,
                            input logic [AddrWidth-1:0] a);
    logic [63:0] rd;
    logic        lerr;
    logic        serr;
    u_mem.fault_beat[a / 8] = 1'b1;
    run_access(wr, t, a, 64'hdead_beef_0bad_f00d, 1'b1, rd, lerr, serr);
    u_mem.fault_beat[a / 8] = 1'b0;
    assert (lerr == !wr) else report_mismatch("load_err_o", 64'(!wr), 64'(lerr));
    assert (serr == wr) else report_mismatch("store_err_o", 64'(wr), 64'(serr));
    check_beats(a, 1, wr); // no second request after a failing first beat
    compare_memory();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic idle_after_reset();
    @(negedge clk);
    assert (!busy) else report_mismatch("busy_o", 64'd0, 64'(busy));
    assert (!valid) else report_mismatch("valid_o", 64'd0, 64'(valid));
    assert (!data_req) else report_mismatch("data_req_o", 64'd0, 64'(data_req));
    assert (!load_err) else report_mismatch("load_err_o", 64'd0, 64'(load_err));
    assert (!store_err) else report_mismatch("store_err_o", 64'd0, 64'(store_err));
  endtask

  // every type, every offset, with and without sign extension
  task automatic loads_every_offset();
    access_type_e types [4];
    types = '{ACC_BYTE, ACC_HALF, ACC_WORD, ACC_DOUBLE};
    for (int ti = 0; ti < 4; ti++) begin
      for (int off = 0; off < 8; off++) begin
        for (int sx = 0; sx < 2; sx++) begin
          load_and_check(types[ti], 32'h100 + 32'(64*ti + 16*sx + off), 1'(sx));
        end
      end
    end
  endtask

  task automatic stores_every_offset();
    access_type_e types [4];
    types = '{ACC_BYTE, ACC_HALF, ACC_WORD, ACC_DOUBLE};
    for (int ti = 0; ti < 4; ti++) begin
      for (int off = 0; off < 8; off++) begin
        store_and_check(types[ti], 32'h200 + 32'(16*ti + off), {$urandom, $urandom});
      end
    end
  endtask

  task automatic bus_errors();
    error_case(1'b0, ACC_WORD, 32'h300); // single beat load
    error_case(1'b1, ACC_HALF, 32'h322); // single beat store
    error_case(1'b0, ACC_WORD, 32'h346); // split load, first beat fails
    error_case(1'b1, ACC_HALF, 32'h367); // split store, first beat fails
  endtask

  task automatic random_mix();
    access_type_e          t;
    logic [AddrWidth-1:0]  a;
    for (int i = 0; i < 200; i++) begin
      t = access_type_e'($urandom_range(0, 3));
      a = $urandom_range(0, MemBytes - 9); // second beat stays inside memory
      if ($urandom_range(0, 1)) begin
        store_and_check(t, a, {$urandom, $urandom});
      end else begin
        load_and_check(t, a, 1'($urandom_range(0, 1)));
      end
      repeat ($urandom_range(0, 2)) @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(84778));
    cycles   = 0;
    rst_n    = 1'b0;
    req      = 1'b0;
    addr     = '0;
    acc_type = ACC_WORD;
    we       = 1'b0;
    wdata    = '0;
    sign_ext = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #10;
    rst_n = 1'b1;
    for (int i = 0; i < MemBytes; i++) begin
      ref_mem[i] = u_mem.mem[i]; // start from the model's fill pattern
    end
    idle_after_reset();
    loads_every_offset();
    stores_every_offset();
    bus_errors();
    random_mix();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- sim.f
hw/lsu_pkg.sv
hw/lsu_bus_pkg.sv
hw/lsu_store_lanes.sv
hw/lsu_load_align.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_top.sv
test/lsu_mem_model.sv
test/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - target: rtl
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_bus_pkg.sv
      - hw/lsu_store_lanes.sv
      - hw/lsu_load_align.sv
      - hw/lsu_ctrl_fsm.sv
      - hw/lsu_top.sv

  - target: test
    files:
      - test/lsu_mem_model.sv
      - test/tb_lsu.sv
